/* Makefile */
VERILATOR ?= verilator
TOP       := rv_core_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# exit status of the simulation is the pass or fail result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

/* common/rv_pkg.sv */
// ********************
// shared widths, encodings and stage payloads for the rv32i pipeline
// an all-zero ctrl_t is a bubble, so every control field is active high
// only word accesses exist, no byte or halfword lanes
// ********************
package rv_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;

  // value in x17 that makes ecall stop the core
  localparam word_t ECALL_HALT_CODE = 32'd10;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OP      = 7'b0110011,
    OP_IMM  = 7'b0010011,
    LOAD    = 7'b0000011,
    STORE   = 7'b0100011,
    SYSTEM  = 7'b1110011,
    ILLEGAL = 7'b0000000  // also what a zeroed IF/ID holds
  } opcode_e;

  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    SLL  = 4'd2,
    SLT  = 4'd3,
    SLTU = 4'd4,
    XOR  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    OR   = 4'd8,
    AND  = 4'd9
  } alu_op_e;

  // operand source for execute
  typedef enum logic [1:0] {
    FWD_NONE = 2'd0,  // register file value from decode
    FWD_MEM  = 2'd1,  // alu result sitting in EX/MEM
    FWD_WB   = 2'd2   // writeback value
  } fwd_sel_e;

  typedef struct packed {
    logic alu_src_imm;  // b operand from imm
    logic mem_read;
    logic mem_write;
    logic mem_to_reg;
    logic reg_write;
    logic is_ecall;
  } ctrl_t;

  typedef struct packed {
    word_t pc;
    word_t inst;
  } if_id_t;

  typedef struct packed {
    ctrl_t    ctrl;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    imm;
    alu_op_e  alu_op;
  } id_ex_t;

  typedef struct packed {
    ctrl_t    ctrl;
    reg_idx_t rd;
    word_t    alu_out;     // also the data memory address
    word_t    store_data;  // rs2 after forwarding
    logic     halt;
  } ex_mem_t;

  typedef struct packed {
    logic     reg_write;
    logic     mem_to_reg;
    reg_idx_t rd;
    word_t    alu_out;
    word_t    load_data;
    logic     halt;
  } mem_wb_t;

  // one register write as seen at writeback
  typedef struct packed {
    reg_idx_t rd;
    word_t    data;
  } wb_trace_t;

endpackage

/* decode/decode_unit.sv */
// ********************
// instruction decode for OP, OP_IMM, LOAD, STORE and ecall
// anything else, ebreak and csr ops included, decodes to a bubble
// ecall reads a7 as rs1, the index swap is done by the core
// ********************
`timescale 1ns/1ps

module decode_unit (
  input  rv_pkg::word_t   inst,
  output rv_pkg::ctrl_t   ctrl,
  output rv_pkg::word_t   imm,
  output rv_pkg::alu_op_e alu_op,
  output logic            uses_rs1,
  output logic            uses_rs2
);
  import rv_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic       bit30;
  word_t      imm_i;
  word_t      imm_s;
  logic       is_ecall;
  alu_op_e    arith_op;

  assign funct3   = inst[14:12];
  assign bit30    = inst[30];
  assign imm_i    = {{20{inst[31]}}, inst[31:20]};
  assign imm_s    = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign is_ecall = (inst[6:0] == SYSTEM) && (inst[31:7] == '0);  // funct12, rs1, rd all zero

  // fold unsupported opcodes onto ILLEGAL
  always_comb begin
    case (inst[6:0])
      OP, OP_IMM, LOAD, STORE, SYSTEM: opcode = opcode_e'(inst[6:0]);
      default:                         opcode = ILLEGAL;
    endcase
  end

  // funct3 map shared by register and immediate forms
  always_comb begin
    case (funct3)
      3'b000:  arith_op = (bit30 && opcode == OP) ? SUB : ADD;  // no subi
      3'b001:  arith_op = SLL;
      3'b010:  arith_op = SLT;
      3'b011:  arith_op = SLTU;
      3'b100:  arith_op = XOR;
      3'b101:  arith_op = bit30 ? SRA : SRL;  // srai/srli share funct3
      3'b110:  arith_op = OR;
      default: arith_op = AND;
    endcase
  end

  always_comb begin
    ctrl     = '0;  // bubble unless a case below fills it
    imm      = '0;
    alu_op   = ADD;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    case (opcode)
      OP: begin
        ctrl.reg_write = 1'b1;
        alu_op         = arith_op;
        uses_rs1       = 1'b1;
        uses_rs2       = 1'b1;
      end
      OP_IMM: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
        imm              = imm_i;
        alu_op           = arith_op;
        uses_rs1         = 1'b1;
      end
      LOAD: begin  // lw only, funct3 not checked
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_read    = 1'b1;
        ctrl.mem_to_reg  = 1'b1;
        ctrl.reg_write   = 1'b1;
        imm              = imm_i;
        uses_rs1         = 1'b1;
      end
      STORE: begin  // sw only
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_write   = 1'b1;
        imm              = imm_s;
        uses_rs1         = 1'b1;
        uses_rs2         = 1'b1;
      end
      SYSTEM: begin
        // ecall passes x17 + 0 through the alu
        ctrl.is_ecall    = is_ecall;
        ctrl.alu_src_imm = is_ecall;
        uses_rs1         = is_ecall;
      end
      default: ;  // ILLEGAL stays a bubble
    endcase
  end

endmodule

/* decode/hazard_unit.sv */
// ********************
// load-use stall and halt flush for the front of the pipe
// stall costs exactly one bubble, the load then forwards from writeback
// ********************
`timescale 1ns/1ps

module hazard_unit (
  input  rv_pkg::reg_idx_t id_rs1,
  input  rv_pkg::reg_idx_t id_rs2,
  input  logic             uses_rs1,
  input  logic             uses_rs2,
  input  rv_pkg::reg_idx_t ex_rd,
  input  logic             ex_mem_read,
  input  logic             halt_seen,
  output logic             stall,
  output logic             flush_front
);

  logic rs1_hit;
  logic rs2_hit;
  logic load_use;

  assign rs1_hit  = uses_rs1 && (id_rs1 == ex_rd);
  assign rs2_hit  = uses_rs2 && (id_rs2 == ex_rd);
  assign load_use = ex_mem_read && (ex_rd != '0) && (rs1_hit || rs2_hit);

  // once halting, the front is emptied each cycle and never stalls
  assign flush_front = halt_seen;
  assign stall       = load_use && !halt_seen;

endmodule

/* execute/alu.sv */
// ********************
// rv32i integer alu, purely combinational
// shift amount is b[4:0], upper bits ignored
// ********************
`timescale 1ns/1ps

module alu (
  input  rv_pkg::alu_op_e op,
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  output rv_pkg::word_t   y
);
  import rv_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b[4:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      ADD:     y = a + b;
      SUB:     y = a - b;
      SLL:     y = a << shamt;
      SLT:     y = {{(XLEN-1){1'b0}}, lt_signed};
      SLTU:    y = {{(XLEN-1){1'b0}}, lt_unsigned};
      XOR:     y = a ^ b;
      SRL:     y = a >> shamt;
      SRA:     y = word_t'($signed(a) >>> shamt);  // sign fill
      OR:      y = a | b;
      AND:     y = a & b;
      default: y = a + b;  // unused encodings
    endcase
  end

endmodule

/* execute/forward_unit.sv */
// ********************
// operand forwarding into execute
// memory stage wins over writeback, rd x0 never forwards
// caller masks mem_reg_write for loads, the stall covers that case
// ********************
`timescale 1ns/1ps

module forward_unit (
  input  rv_pkg::reg_idx_t ex_rs1,
  input  rv_pkg::reg_idx_t ex_rs2,
  input  rv_pkg::reg_idx_t mem_rd,
  input  rv_pkg::reg_idx_t wb_rd,
  input  logic             mem_reg_write,
  input  logic             wb_reg_write,
  output rv_pkg::fwd_sel_e fwd_a,
  output rv_pkg::fwd_sel_e fwd_b
);
  import rv_pkg::*;

  function automatic fwd_sel_e pick(input reg_idx_t rs);
    fwd_sel_e sel;
    if (mem_reg_write && mem_rd != '0 && mem_rd == rs) begin
      sel = FWD_MEM;  // youngest producer
    end else if (wb_reg_write && wb_rd != '0 && wb_rd == rs) begin
      sel = FWD_WB;
    end else begin
      sel = FWD_NONE;
    end
    return sel;
  endfunction

  always_comb begin
    fwd_a = pick(ex_rs1);
    fwd_b = pick(ex_rs2);
  end

endmodule

/* sim.f */
common/rv_pkg.sv
src/pipe_reg.sv
src/reg_file.sv
src/mem_array.sv
decode/decode_unit.sv
decode/hazard_unit.sv
execute/alu.sv
execute/forward_unit.sv
src/rv_core.sv
verification/clk_gen.sv
verification/rv_core_tb.sv

/* src/mem_array.sv */
// ********************
// word memory, combinational read and synchronous write
// addresses are byte addresses, bits 1:0 ignored
// DEPTH must be a power of two, upper address bits wrap
// contents are not cleared by reset
// ********************
`timescale 1ns/1ps

module mem_array #(
  parameter int DEPTH = 256
) (
  input  logic          clk,
  input  logic          we,
  input  rv_pkg::word_t waddr,
  input  rv_pkg::word_t wdata,
  input  rv_pkg::word_t raddr,
  output rv_pkg::word_t rdata
);
  import rv_pkg::*;

  localparam int AW = $clog2(DEPTH);

  word_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr[AW+1:2]] <= wdata;  // word index modulo DEPTH
    end
  end

  assign rdata = mem[raddr[AW+1:2]];

endmodule

/* src/pipe_reg.sv */
// ********************
// generic stage register
// flush and reset load all zeros, which must decode as a bubble
// flush wins over stall
// ********************
`timescale 1ns/1ps

module pipe_reg #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     stall,  // keep current contents
  input  logic     flush,  // insert bubble
  input  payload_t d,
  output payload_t q
);

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      q <= '0;
    end else if (!stall) begin
      q <= d;
    end
  end

endmodule

/* src/reg_file.sv */
// ********************
// 32 x 32 register file, two read ports and one write port
// x0 has no storage and always reads zero
// a read of the register being written returns the new value
// ********************
`timescale 1ns/1ps

module reg_file (
  input  logic             clk,
  input  logic             reset,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  input  rv_pkg::reg_idx_t rd,
  input  rv_pkg::word_t    rd_data,
  input  logic             we,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data
);
  import rv_pkg::*;

  word_t regs [1:31];  // x1..x31 only

  // write-through so decode sees the writeback value in the same cycle
  function automatic word_t read_port(input reg_idx_t idx);
    word_t val;
    if (idx == '0) begin
      val = '0;
    end else if (we && idx == rd) begin
      val = rd_data;
    end else begin
      val = regs[idx];
    end
    return val;
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin  // writes to x0 dropped
      regs[rd] <= rd_data;
    end
  end

  always_comb begin
    rs1_data = read_port(rs1);
    rs2_data = read_port(rs2);
  end

endmodule

/* src/rv_core.sv */
// ********************
// five-stage rv32i core, in order, no branches or jumps
// imem is written through the prog port only while reset is high
// halt: ecall with x17 == 10, sticky until reset
// wb_valid pulses for each register write with rd != x0
// ********************
`timescale 1ns/1ps

module rv_core #(
  parameter int IMEM_WORDS = 256,
  parameter int DMEM_WORDS = 256
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              prog_we,
  input  rv_pkg::word_t     prog_addr,
  input  rv_pkg::word_t     prog_data,
  output logic              wb_valid,
  output rv_pkg::wb_trace_t wb_trace,
  output logic              halted
);
  import rv_pkg::*;

  localparam reg_idx_t ECALL_ARG_REG = 5'd17;  // a7

  word_t    pc;
  word_t    imem_rdata;
  if_id_t   if_id_d;
  if_id_t   if_id_q;
  id_ex_t   id_ex_d;
  id_ex_t   id_ex_q;
  ex_mem_t  ex_mem_d;
  ex_mem_t  ex_mem_q;
  mem_wb_t  mem_wb_d;
  mem_wb_t  mem_wb_q;
  ctrl_t    id_ctrl;
  word_t    id_imm;
  alu_op_e  id_alu_op;
  logic     uses_rs1;
  logic     uses_rs2;
  reg_idx_t id_rs1;
  word_t    rs1_data;
  word_t    rs2_data;
  logic     stall;
  logic     flush_front;
  logic     halt_ex;
  logic     halt_seen;
  logic     halt_q;
  fwd_sel_e fwd_a;
  fwd_sel_e fwd_b;
  word_t    op_a;
  word_t    op_b;
  word_t    rs2_fwd;
  word_t    alu_y;
  word_t    dmem_rdata;
  word_t    wb_data;

  // fetch
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (!stall && !flush_front) begin  // frozen on load-use or halt
      pc <= pc + 32'd4;
    end
  end

  mem_array #(.DEPTH(IMEM_WORDS)) i_imem (
    .clk   (clk),
    .we    (prog_we & reset),  // program load window
    .waddr (prog_addr),
    .wdata (prog_data),
    .raddr (pc),
    .rdata (imem_rdata)
  );

  always_comb begin
    if_id_d.pc   = pc;
    if_id_d.inst = imem_rdata;
  end

  pipe_reg #(.payload_t(if_id_t)) i_if_id (
    .clk   (clk),
    .reset (reset),
    .stall (stall),
    .flush (flush_front),
    .d     (if_id_d),
    .q     (if_id_q)
  );

  // decode
  decode_unit i_decode (
    .inst     (if_id_q.inst),
    .ctrl     (id_ctrl),
    .imm      (id_imm),
    .alu_op   (id_alu_op),
    .uses_rs1 (uses_rs1),
    .uses_rs2 (uses_rs2)
  );

  assign id_rs1 = id_ctrl.is_ecall ? ECALL_ARG_REG : if_id_q.inst[19:15];

  reg_file i_reg_file (
    .clk      (clk),
    .reset    (reset),
    .rs1      (id_rs1),
    .rs2      (if_id_q.inst[24:20]),
    .rd       (mem_wb_q.rd),
    .rd_data  (wb_data),
    .we       (mem_wb_q.reg_write),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  hazard_unit i_hazard (
    .id_rs1      (id_rs1),
    .id_rs2      (if_id_q.inst[24:20]),
    .uses_rs1    (uses_rs1),
    .uses_rs2    (uses_rs2),
    .ex_rd       (id_ex_q.rd),
    .ex_mem_read (id_ex_q.ctrl.mem_read),
    .halt_seen   (halt_seen),
    .stall       (stall),
    .flush_front (flush_front)
  );

  always_comb begin
    id_ex_d.ctrl     = id_ctrl;
    id_ex_d.rs1      = id_rs1;
    id_ex_d.rs2      = if_id_q.inst[24:20];
    id_ex_d.rd       = if_id_q.inst[11:7];
    id_ex_d.rs1_data = rs1_data;
    id_ex_d.rs2_data = rs2_data;
    id_ex_d.imm      = id_imm;
    id_ex_d.alu_op   = id_alu_op;
  end

  // bubble into execute on load-use as well as on halt
  pipe_reg #(.payload_t(id_ex_t)) i_id_ex (
    .clk   (clk),
    .reset (reset),
    .stall (1'b0),
    .flush (stall | flush_front),
    .d     (id_ex_d),
    .q     (id_ex_q)
  );

  // execute
  forward_unit i_forward (
    .ex_rs1        (id_ex_q.rs1),
    .ex_rs2        (id_ex_q.rs2),
    .mem_rd        (ex_mem_q.rd),
    .wb_rd         (mem_wb_q.rd),
    .mem_reg_write (ex_mem_q.ctrl.reg_write & ~ex_mem_q.ctrl.mem_read),  // load data not ready
    .wb_reg_write  (mem_wb_q.reg_write),
    .fwd_a         (fwd_a),
    .fwd_b         (fwd_b)
  );

  always_comb begin
    case (fwd_a)
      FWD_MEM: op_a = ex_mem_q.alu_out;
      FWD_WB:  op_a = wb_data;
      default: op_a = id_ex_q.rs1_data;
    endcase
    case (fwd_b)
      FWD_MEM: rs2_fwd = ex_mem_q.alu_out;
      FWD_WB:  rs2_fwd = wb_data;
      default: rs2_fwd = id_ex_q.rs2_data;
    endcase
    op_b = id_ex_q.ctrl.alu_src_imm ? id_ex_q.imm : rs2_fwd;
  end

  alu i_alu (
    .op (id_ex_q.alu_op),
    .a  (op_a),
    .b  (op_b),
    .y  (alu_y)
  );

  // halting ecall, judged on the forwarded x17
  assign halt_ex   = id_ex_q.ctrl.is_ecall && (op_a == ECALL_HALT_CODE);
  assign halt_seen = halt_ex | ex_mem_q.halt | mem_wb_q.halt | halt_q;

  always_comb begin
    ex_mem_d.ctrl       = id_ex_q.ctrl;
    ex_mem_d.rd         = id_ex_q.rd;
    ex_mem_d.alu_out    = alu_y;
    ex_mem_d.store_data = rs2_fwd;  // store data after forwarding
    ex_mem_d.halt       = halt_ex;
  end

  pipe_reg #(.payload_t(ex_mem_t)) i_ex_mem (
    .clk   (clk),
    .reset (reset),
    .stall (1'b0),
    .flush (1'b0),
    .d     (ex_mem_d),
    .q     (ex_mem_q)
  );

  // memory
  mem_array #(.DEPTH(DMEM_WORDS)) i_dmem (
    .clk   (clk),
    .we    (ex_mem_q.ctrl.mem_write),
    .waddr (ex_mem_q.alu_out),
    .wdata (ex_mem_q.store_data),
    .raddr (ex_mem_q.alu_out),
    .rdata (dmem_rdata)
  );

  always_comb begin
    mem_wb_d.reg_write  = ex_mem_q.ctrl.reg_write;
    mem_wb_d.mem_to_reg = ex_mem_q.ctrl.mem_to_reg;
    mem_wb_d.rd         = ex_mem_q.rd;
    mem_wb_d.alu_out    = ex_mem_q.alu_out;
    mem_wb_d.load_data  = dmem_rdata;
    mem_wb_d.halt       = ex_mem_q.halt;
  end

  pipe_reg #(.payload_t(mem_wb_t)) i_mem_wb (
    .clk   (clk),
    .reset (reset),
    .stall (1'b0),
    .flush (1'b0),
    .d     (mem_wb_d),
    .q     (mem_wb_q)
  );

  // writeback
  assign wb_data = mem_wb_q.mem_to_reg ? mem_wb_q.load_data : mem_wb_q.alu_out;

  always_ff @(posedge clk) begin
    if (reset) begin
      halt_q <= 1'b0;
    end else if (mem_wb_q.halt) begin
      halt_q <= 1'b1;  // held until reset
    end
  end

  assign halted   = halt_q | mem_wb_q.halt;  // up while the ecall is in writeback
  assign wb_valid = mem_wb_q.reg_write && (mem_wb_q.rd != '0);

  always_comb begin
    wb_trace.rd   = mem_wb_q.rd;
    wb_trace.data = wb_data;
  end

endmodule

/* verification/clk_gen.sv */
// ********************
// testbench clock and synchronous reset source
// 4 ns period, reset high for at least RESET_CYCLES rising edges
// hold keeps reset high past that, e.g. while a program is loaded
// reset drops on a rising edge, never mid-cycle
// ********************
`timescale 1ns/1ps

module clk_gen #(
  parameter int HALF_PERIOD  = 2,   // ns
  parameter int RESET_CYCLES = 10
) (
  input  logic hold,   // stretch reset while high
  output logic clk,
  output logic reset
);

  logic clk_r   = 1'b0;
  logic reset_r = 1'b1;  // asserted from time zero
  int   cycles  = 0;

  always #(HALF_PERIOD) clk_r = ~clk_r;

  // count reset edges, release once the minimum is met and hold is gone
  always @(posedge clk_r) begin
    if (reset_r) begin
      cycles <= cycles + 1;
      if (cycles >= RESET_CYCLES - 1 && !hold) begin
        reset_r <= 1'b0;
      end
    end
  end

  assign clk   = clk_r;
  assign reset = reset_r;

endmodule

/* verification/rv_core_tb.sv */
// ********************
// testbench for rv_core
// program goes in through the prog port while reset is high
// every wb_valid pulse is checked in order against the expected trace
// halted is checked each cycle, it must rise on a known cycle and stay up
// first mismatch ends the run
// ********************
`timescale 1ns/1ps

module rv_core_tb;
  import rv_pkg::*;

  localparam int N_PROG  = 44;
  localparam int N_TRACE = 35;
  // halting ecall is word 40, two load-use stalls before it, four stages to writeback
  localparam int HALT_CYCLE      = 4 + 40 + 2;
  localparam int DRAIN_CYCLES    = 10;  // quiet cycles watched after halt
  localparam int WATCHDOG_CYCLES = (N_PROG + N_TRACE) * 8 + N_PROG + 12;

  localparam logic [6:0] OPC_OP    = 7'b0110011;
  localparam logic [6:0] OPC_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;
  localparam word_t      ECALL     = 32'h0000_0073;

  logic      clk;
  logic      reset;
  logic      load_hold = 1'b1;  // keeps reset up until the loader is done
  logic      prog_we   = 1'b0;
  word_t     prog_addr = '0;
  word_t     prog_data = '0;
  logic      wb_valid;
  wb_trace_t wb_trace;
  logic      halted;

  word_t     prog [N_PROG];
  wb_trace_t exp_trace [N_TRACE];
  int        trace_idx = 0;  // next expected retirement
  int        cyc;            // cycles since reset release

  clk_gen #(.HALF_PERIOD(2), .RESET_CYCLES(10)) i_clk_gen (
    .hold  (load_hold),
    .clk   (clk),
    .reset (reset)
  );

  rv_core #(.IMEM_WORDS(64), .DMEM_WORDS(64)) i_dut (
    .clk       (clk),
    .reset     (reset),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .wb_valid  (wb_valid),
    .wb_trace  (wb_trace),
    .halted    (halted)
  );

  // instruction encoders, rv32i base formats
  function automatic word_t rtype_word(input int rd, input int rs1, input int rs2,
                                       input logic [2:0] f3, input logic [6:0] f7);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
  endfunction

  function automatic word_t itype_word(input int rd, input int rs1, input int imm,
                                       input logic [2:0] f3, input logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};  // shifts put funct7 in imm[11:5]
  endfunction

  function automatic word_t sw_word(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPC_STORE};
  endfunction

  task automatic fill_tables();
    // dependent r-type chain
    prog[0]  = itype_word(1, 0, 5, 3'd0, OPC_IMM);         // addi x1, x0, 5
    prog[1]  = itype_word(2, 0, -3, 3'd0, OPC_IMM);        // addi x2, x0, -3
    prog[2]  = rtype_word(3, 1, 2, 3'd0, 7'h00);           // add  x3, x1, x2
    prog[3]  = rtype_word(4, 3, 1, 3'd0, 7'h20);           // sub  x4, x3, x1
    prog[4]  = rtype_word(5, 4, 3, 3'd4, 7'h00);           // xor  x5, x4, x3
    prog[5]  = rtype_word(6, 5, 1, 3'd6, 7'h00);           // or   x6, x5, x1
    prog[6]  = rtype_word(7, 4, 6, 3'd7, 7'h00);           // and  x7, x4, x6
    prog[7]  = rtype_word(8, 2, 1, 3'd2, 7'h00);           // slt  x8, x2, x1
    prog[8]  = rtype_word(9, 2, 1, 3'd3, 7'h00);           // sltu x9, x2, x1
    prog[9]  = rtype_word(10, 1, 8, 3'd1, 7'h00);          // sll  x10, x1, x8
    prog[10] = rtype_word(11, 2, 10, 3'd5, 7'h00);         // srl  x11, x2, x10
    prog[11] = rtype_word(12, 2, 10, 3'd5, 7'h20);         // sra  x12, x2, x10
    // immediates, negative and edge shifts
    prog[12] = itype_word(13, 1, -2048, 3'd0, OPC_IMM);    // addi  x13, x1, -2048
    prog[13] = itype_word(14, 13, -1, 3'd4, OPC_IMM);      // xori  x14, x13, -1
    prog[14] = itype_word(15, 2, 'h7f0, 3'd7, OPC_IMM);    // andi  x15, x2, 0x7f0
    prog[15] = itype_word(16, 0, -256, 3'd6, OPC_IMM);     // ori   x16, x0, -256
    prog[16] = itype_word(18, 1, -1, 3'd2, OPC_IMM);       // slti  x18, x1, -1
    prog[17] = itype_word(19, 1, -1, 3'd3, OPC_IMM);       // sltiu x19, x1, -1
    prog[18] = itype_word(20, 2, 31, 3'd1, OPC_IMM);       // slli  x20, x2, 31
    prog[19] = itype_word(21, 2, 0, 3'd1, OPC_IMM);        // slli  x21, x2, 0
    prog[20] = itype_word(22, 2, 31, 3'd5, OPC_IMM);       // srli  x22, x2, 31
    prog[21] = itype_word(23, 16, 0, 3'd5, OPC_IMM);       // srli  x23, x16, 0
    prog[22] = itype_word(24, 16, 'h41f, 3'd5, OPC_IMM);   // srai  x24, x16, 31
    prog[23] = itype_word(25, 13, 'h400, 3'd5, OPC_IMM);   // srai  x25, x13, 0
    prog[24] = itype_word(26, 13, 'h404, 3'd5, OPC_IMM);   // srai  x26, x13, 4
    // store, load, use
    prog[25] = itype_word(27, 0, 64, 3'd0, OPC_IMM);       // addi x27, x0, 64
    prog[26] = sw_word(13, 27, 8);                         // sw   x13, 8(x27)
    prog[27] = itype_word(28, 27, 8, 3'd2, OPC_LOAD);      // lw   x28, 8(x27)
    prog[28] = rtype_word(29, 28, 1, 3'd0, 7'h00);         // add  x29, x28, x1  stall
    prog[29] = sw_word(29, 27, -4);                        // sw   x29, -4(x27)
    prog[30] = itype_word(30, 27, -4, 3'd2, OPC_LOAD);     // lw   x30, -4(x27)
    prog[31] = rtype_word(31, 1, 30, 3'd0, 7'h20);         // sub  x31, x1, x30  stall on rs2
    // x0 as destination and source
    prog[32] = itype_word(0, 1, 7, 3'd0, OPC_IMM);         // addi x0, x1, 7
    prog[33] = rtype_word(0, 1, 1, 3'd0, 7'h00);           // add  x0, x1, x1
    prog[34] = rtype_word(5, 0, 1, 3'd0, 7'h00);           // add  x5, x0, x1
    prog[35] = rtype_word(6, 0, 0, 3'd6, 7'h00);           // or   x6, x0, x0
    // ecall, first as a no-op, then halting
    prog[36] = itype_word(17, 0, 9, 3'd0, OPC_IMM);        // addi x17, x0, 9
    prog[37] = ECALL;
    prog[38] = itype_word(7, 17, 1, 3'd0, OPC_IMM);        // addi x7, x17, 1
    prog[39] = itype_word(17, 7, 0, 3'd0, OPC_IMM);        // addi x17, x7, 0
    prog[40] = ECALL;
    prog[41] = itype_word(1, 0, 99, 3'd0, OPC_IMM);        // never retires
    prog[42] = itype_word(2, 0, 77, 3'd0, OPC_IMM);
    prog[43] = sw_word(1, 0, 0);

    // rd, value per retirement, worked out by hand
    exp_trace[0]  = '{5'd1, 32'h0000_0005};
    exp_trace[1]  = '{5'd2, 32'hffff_fffd};
    exp_trace[2]  = '{5'd3, 32'h0000_0002};
    exp_trace[3]  = '{5'd4, 32'hffff_fffd};   // 2 - 5
    exp_trace[4]  = '{5'd5, 32'hffff_ffff};
    exp_trace[5]  = '{5'd6, 32'hffff_ffff};
    exp_trace[6]  = '{5'd7, 32'hffff_fffd};
    exp_trace[7]  = '{5'd8, 32'h0000_0001};   // -3 < 5 signed
    exp_trace[8]  = '{5'd9, 32'h0000_0000};   // not below unsigned
    exp_trace[9]  = '{5'd10, 32'h0000_000a};
    exp_trace[10] = '{5'd11, 32'h003f_ffff};
    exp_trace[11] = '{5'd12, 32'hffff_ffff};
    exp_trace[12] = '{5'd13, 32'hffff_f805};  // 5 - 2048
    exp_trace[13] = '{5'd14, 32'h0000_07fa};
    exp_trace[14] = '{5'd15, 32'h0000_07f0};
    exp_trace[15] = '{5'd16, 32'hffff_ff00};
    exp_trace[16] = '{5'd18, 32'h0000_0000};  // 5 not below -1 signed
    exp_trace[17] = '{5'd19, 32'h0000_0001};  // imm -1 is all ones unsigned
    exp_trace[18] = '{5'd20, 32'h8000_0000};
    exp_trace[19] = '{5'd21, 32'hffff_fffd};
    exp_trace[20] = '{5'd22, 32'h0000_0001};
    exp_trace[21] = '{5'd23, 32'hffff_ff00};
    exp_trace[22] = '{5'd24, 32'hffff_ffff};
    exp_trace[23] = '{5'd25, 32'hffff_f805};
    exp_trace[24] = '{5'd26, 32'hffff_ff80};
    exp_trace[25] = '{5'd27, 32'h0000_0040};
    exp_trace[26] = '{5'd28, 32'hffff_f805};  // loaded back
    exp_trace[27] = '{5'd29, 32'hffff_f80a};
    exp_trace[28] = '{5'd30, 32'hffff_f80a};
    exp_trace[29] = '{5'd31, 32'h0000_07fb};  // 5 - (-2038)
    exp_trace[30] = '{5'd5, 32'h0000_0005};
    exp_trace[31] = '{5'd6, 32'h0000_0000};
    exp_trace[32] = '{5'd17, 32'h0000_0009};
    exp_trace[33] = '{5'd7, 32'h0000_000a};
    exp_trace[34] = '{5'd17, 32'h0000_000a};
  endtask

  // one word per rising edge, then let reset go
  task automatic load_program();
    for (int i = 0; i < N_PROG; i++) begin
      @(posedge clk);
      prog_we   <= 1'b1;
      prog_addr <= word_t'(i * 4);
      prog_data <= prog[i];
    end
    @(posedge clk);
    prog_we   <= 1'b0;
    load_hold <= 1'b0;
  endtask

  task automatic check_trace(input wb_trace_t got, input wb_trace_t exp, input int idx);
    if (got !== exp) begin
      $display("Fail at %0t: wb_trace retirement %0d got rd=x%0d data=%h, expected rd=x%0d data=%h",
               $time, idx, got.rd, got.data, exp.rd, exp.data);
      $display("Result: FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_halt(input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail at %0t: halted got %b expected %b (cycle %0d)", $time, got, exp, cyc);
      $display("Result: FAILED");
      $fatal(1);
    end
  endtask

  always @(posedge clk) begin
    if (reset) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  // trace monitor, sampled mid-cycle where the writeback outputs are settled
  always @(negedge clk) begin
    if (!reset && wb_valid) begin
      if (trace_idx >= N_TRACE) begin
        $display("unexpected register write to x%0d at %0t after the last expected retirement",
                 wb_trace.rd, $time);
        $display("Result: FAILED");
        $fatal(1);
      end else begin
        check_trace(wb_trace, exp_trace[trace_idx], trace_idx);
        trace_idx++;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the core did not finish", WATCHDOG_CYCLES);
    $display("Result: FAILED");
    $fatal(1);
  end

  initial begin
    fill_tables();
    load_program();
    while (reset) @(negedge clk);
    // low before the ecall reaches writeback, high from then on
    while (cyc < HALT_CYCLE + DRAIN_CYCLES) begin
      check_halt(halted, (cyc >= HALT_CYCLE));
      @(negedge clk);
    end
    @(posedge clk);
    if (trace_idx == N_TRACE) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("only %0d of %0d expected register writes were traced", trace_idx, N_TRACE);
      $display("Result: FAILED");
      $fatal(1);
    end
  end

endmodule
